// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

	////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////
	localparam int REG_WIDTH       = 16;
	localparam int REG_ADDR_WIDTH  = 4;
	localparam int NUM_REGS        = 16;
	localparam int REG_DEBUG_WIDTH = REG_WIDTH * NUM_REGS;

	// Opcodes
	localparam logic [3:0] OP_NOP  = 4'h0;
	localparam logic [3:0] OP_ADD  = 4'h1;
	localparam logic [3:0] OP_SUB  = 4'h2;
	localparam logic [3:0] OP_AND  = 4'h3;
	localparam logic [3:0] OP_OR   = 4'h4;
	localparam logic [3:0] OP_XOR  = 4'h5;
	localparam logic [3:0] OP_SLL  = 4'h6;
	localparam logic [3:0] OP_LI   = 4'h8;
	localparam logic [3:0] OP_ADDI = 4'h9;

	////////////////////////////////////////////////////////////
	// LED view codes, selected by sw[15:8]
	////////////////////////////////////////////////////////////
	localparam logic [7:0] LED_STATUS   = 8'h00;
	localparam logic [7:0] LED_ADDRS    = 8'h06;
	localparam logic [7:0] LED_EXE_PC   = 8'h16;
	localparam logic [7:0] LED_EXE_INST = 8'h17;
	localparam logic [7:0] LED_ALU_OP1  = 8'h19;
	localparam logic [7:0] LED_ALU_OP2  = 8'h1A;
	localparam logic [7:0] LED_ALU_RES  = 8'h1B;
	localparam logic [7:0] LED_RETIRED  = 8'h20;
	// 30..3F, highest code is register 0
	localparam logic [7:0] LED_REG_BASE = 8'h30;
	localparam logic [7:0] LED_QPTR     = 8'h40;
	localparam logic [7:0] LED_QHEAD    = 8'h41;

	// Instruction word, register and immediate forms
	typedef struct packed {
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
	} r_inst_t;

	typedef struct packed {
		logic [3:0] op;
		logic [3:0] rd;
		logic [7:0] imm;
	} i_inst_t;

	typedef union packed {
		r_inst_t r;
		i_inst_t i;
	} inst_t;

endpackage

// ==== rtl/inst_queue.sv ====
`timescale 1ns/1ps

module inst_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           inst_valid,
	input  logic [cpu_pkg::REG_WIDTH-1:0]  inst_data,
	output logic                           inst_ready,
	input  logic                           q_pop,
	output logic                           q_valid,
	output logic [cpu_pkg::REG_WIDTH-1:0]  q_head,
	output logic [7:0]                     qfront,
	output logic [7:0]                     qtail
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	logic [cpu_pkg::REG_WIDTH-1:0] mem [QUEUE_DEPTH];
	logic [PTR_W-1:0]              rd_ptr;
	logic [PTR_W-1:0]              wr_ptr;
	logic [CNT_W-1:0]              count;
	logic                          push;

	assign inst_ready = (count != CNT_W'(QUEUE_DEPTH));
	assign q_valid    = (count != '0);
	assign push       = inst_valid && inst_ready;
	assign q_head     = mem[rd_ptr];

	// Pointers shown on LEDs as full bytes
	assign qfront = 8'(rd_ptr);
	assign qtail  = 8'(wr_ptr);

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= inst_data;
		end
	end

	// Power-of-two depth, pointers wrap on overflow
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (q_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, q_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////
	a_pop_not_empty: assert property (@(posedge clk) disable iff (rst)
		q_pop |-> q_valid);

	a_count_bound: assert property (@(posedge clk) disable iff (rst)
		count <= CNT_W'(QUEUE_DEPTH));

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0]  rs_addr,
	input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0]  rt_addr,
	output logic [cpu_pkg::REG_WIDTH-1:0]       rs_value,
	output logic [cpu_pkg::REG_WIDTH-1:0]       rt_value,
	input  logic                                wr_en,
	input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0]  wr_addr,
	input  logic [cpu_pkg::REG_WIDTH-1:0]       wr_value,
	output logic [cpu_pkg::REG_DEBUG_WIDTH-1:0] reg_debug_out
);

	logic [cpu_pkg::REG_WIDTH-1:0] regs [cpu_pkg::NUM_REGS];

	// Asynchronous read ports
	assign rs_value = regs[rs_addr];
	assign rt_value = regs[rt_addr];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_value;
		end
	end

	// Flat dump, register 0 in the low word
	for (genvar g = 0; g < cpu_pkg::NUM_REGS; g++) begin : g_dump
		assign reg_debug_out[g*cpu_pkg::REG_WIDTH +: cpu_pkg::REG_WIDTH] = regs[g];
	end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  logic [3:0]                    op,
	input  logic [cpu_pkg::REG_WIDTH-1:0] op1,
	input  logic [cpu_pkg::REG_WIDTH-1:0] op2,
	output logic [cpu_pkg::REG_WIDTH-1:0] res,
	output logic                          zero
);

	always_comb begin
		case (op)
			cpu_pkg::OP_ADD: begin
				res = op1 + op2;
			end
			cpu_pkg::OP_SUB: begin
				res = op1 - op2;
			end
			cpu_pkg::OP_AND: begin
				res = op1 & op2;
			end
			cpu_pkg::OP_OR: begin
				res = op1 | op2;
			end
			cpu_pkg::OP_XOR: begin
				res = op1 ^ op2;
			end
			// Shift amount is the low nibble only
			cpu_pkg::OP_SLL: begin
				res = op1 << op2[3:0];
			end
			cpu_pkg::OP_LI: begin
				res = op2;
			end
			cpu_pkg::OP_ADDI: begin
				res = op1 + op2;
			end
			default: begin
				res = '0;
			end
		endcase
	end

	assign zero = (res == '0);

endmodule

// ==== rtl/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               hold,
	input  logic                               q_valid,
	input  logic [cpu_pkg::REG_WIDTH-1:0]      q_head,
	output logic                               q_pop,
	output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rs_addr,
	output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] rt_addr,
	input  logic [cpu_pkg::REG_WIDTH-1:0]      rs_value,
	input  logic [cpu_pkg::REG_WIDTH-1:0]      rt_value,
	output logic                               wr_en,
	output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] wr_addr,
	output logic [cpu_pkg::REG_WIDTH-1:0]      wr_value,
	output logic                               retire_valid,
	output logic                               retire_write,
	output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] retire_addr,
	output logic [cpu_pkg::REG_WIDTH-1:0]      retire_value,
	output logic                               retire_error,
	output logic [cpu_pkg::REG_WIDTH-1:0]      exe_pc,
	output logic [cpu_pkg::REG_WIDTH-1:0]      exe_inst,
	output logic [cpu_pkg::REG_WIDTH-1:0]      alu_op1,
	output logic [cpu_pkg::REG_WIDTH-1:0]      alu_op2,
	output logic [cpu_pkg::REG_WIDTH-1:0]      alu_res,
	output logic                               alu_flag,
	output logic                               decoder_error,
	output logic [cpu_pkg::REG_WIDTH-1:0]      retired_cnt
);

	cpu_pkg::inst_t                inst;
	logic [cpu_pkg::REG_WIDTH-1:0] op2;
	logic [cpu_pkg::REG_WIDTH-1:0] res;
	logic                          zero;
	logic                          dec_err;
	logic                          is_nop;

	assign inst  = q_head;
	assign q_pop = q_valid && !hold;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////
	always_comb begin
		dec_err = 1'b0;
		op2     = rt_value;
		case (inst.r.op)
			cpu_pkg::OP_NOP, cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
			cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_SLL: begin
				op2 = rt_value;
			end
			cpu_pkg::OP_LI: begin
				op2 = {{(cpu_pkg::REG_WIDTH-8){1'b0}}, inst.i.imm};
			end
			cpu_pkg::OP_ADDI: begin
				op2 = {{(cpu_pkg::REG_WIDTH-8){inst.i.imm[7]}}, inst.i.imm};
			end
			default: begin
				dec_err = 1'b1;
			end
		endcase
	end

	assign is_nop = (inst.r.op == cpu_pkg::OP_NOP);

	// ADDI accumulates into rd
	assign rs_addr = (inst.i.op == cpu_pkg::OP_ADDI) ? inst.i.rd : inst.r.rs;
	assign rt_addr = inst.r.rt;

	alu u_alu (
		.op   (inst.r.op),
		.op1  (rs_value),
		.op2  (op2),
		.res  (res),
		.zero (zero)
	);

	assign wr_en    = q_pop && !is_nop && !dec_err;
	assign wr_addr  = inst.r.rd;
	assign wr_value = res;

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= q_pop;
		end
	end

	always_ff @(posedge clk) begin
		if (q_pop) begin
			retire_write <= wr_en;
			retire_addr  <= inst.r.rd;
			retire_value <= res;
			retire_error <= dec_err;
		end
	end

	// Last-executed views
	always_ff @(posedge clk) begin
		if (rst) begin
			exe_pc        <= '0;
			exe_inst      <= '0;
			alu_op1       <= '0;
			alu_op2       <= '0;
			alu_res       <= '0;
			alu_flag      <= 1'b0;
			decoder_error <= 1'b0;
			retired_cnt   <= '0;
		end else if (q_pop) begin
			exe_pc        <= retired_cnt;
			exe_inst      <= q_head;
			alu_op1       <= rs_value;
			alu_op2       <= op2;
			alu_res       <= res;
			alu_flag      <= zero;
			decoder_error <= dec_err;
			retired_cnt   <= retired_cnt + 1'b1;
		end
	end

	// Popped instruction word comes from a written queue entry
	a_pop_known: assert property (@(posedge clk) disable iff (rst)
		q_pop |-> !$isunknown(q_head));

endmodule

// ==== rtl/led_ctrl.sv ====
`timescale 1ns/1ps

module led_ctrl #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [15:0]                         sw,
	output logic [15:0]                         led_data,
	input  logic                                hold,
	input  logic                                inst_ready,
	input  logic                                q_valid,
	input  logic                                decoder_error,
	input  logic                                alu_flag,
	input  logic [cpu_pkg::REG_WIDTH-1:0]       exe_pc,
	input  logic [cpu_pkg::REG_WIDTH-1:0]       exe_inst,
	input  logic [cpu_pkg::REG_WIDTH-1:0]       alu_op1,
	input  logic [cpu_pkg::REG_WIDTH-1:0]       alu_op2,
	input  logic [cpu_pkg::REG_WIDTH-1:0]       alu_res,
	input  logic [cpu_pkg::REG_WIDTH-1:0]       retired_cnt,
	input  logic [cpu_pkg::REG_DEBUG_WIDTH-1:0] reg_debug_out,
	input  logic [7:0]                          qfront,
	input  logic [7:0]                          qtail,
	input  logic [cpu_pkg::REG_WIDTH-1:0]       q_head
);

	logic [7:0] view;
	logic       is_reg_view;
	logic [3:0] reg_idx;

	assign view = sw[15:8];

	// Code 3F is register 0, 30 is register 15
	assign is_reg_view = (view[7:4] == cpu_pkg::LED_REG_BASE[7:4]);
	assign reg_idx     = ~view[3:0];

	////////////////////////////////////////////////////////////
	// View select
	////////////////////////////////////////////////////////////
	always_comb begin
		case (view)
			cpu_pkg::LED_STATUS: begin
				led_data = {hold, 1'b0, inst_ready, 1'b0, q_valid, 1'b0,
					decoder_error, 1'b0, alu_flag, 7'b0};
			end
			// rd, rs, rt fields of the last instruction
			cpu_pkg::LED_ADDRS:    led_data = {exe_inst[11:0], 4'b0};
			cpu_pkg::LED_EXE_PC:   led_data = exe_pc;
			cpu_pkg::LED_EXE_INST: led_data = exe_inst;
			cpu_pkg::LED_ALU_OP1:  led_data = alu_op1;
			cpu_pkg::LED_ALU_OP2:  led_data = alu_op2;
			cpu_pkg::LED_ALU_RES:  led_data = alu_res;
			cpu_pkg::LED_RETIRED:  led_data = retired_cnt;
			cpu_pkg::LED_QPTR:     led_data = {qfront, qtail};
			cpu_pkg::LED_QHEAD:    led_data = q_head;
			default: begin
				if (is_reg_view) begin
					led_data = reg_debug_out[reg_idx*cpu_pkg::REG_WIDTH +: cpu_pkg::REG_WIDTH];
				end else begin
					led_data = sw;
				end
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////
	a_sw_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(sw));

endmodule

// ==== rtl/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               inst_valid,
	input  logic [cpu_pkg::REG_WIDTH-1:0]      inst_data,
	output logic                               inst_ready,
	input  logic                               hold,
	input  logic [15:0]                        sw,
	output logic [15:0]                        led_data,
	output logic                               retire_valid,
	output logic                               retire_write,
	output logic [cpu_pkg::REG_ADDR_WIDTH-1:0] retire_addr,
	output logic [cpu_pkg::REG_WIDTH-1:0]      retire_value,
	output logic                               retire_error
);

	// Queue to execute
	logic                          q_valid;
	logic                          q_pop;
	logic [cpu_pkg::REG_WIDTH-1:0] q_head;
	logic [7:0]                    qfront;
	logic [7:0]                    qtail;

	// Register file ports
	logic [cpu_pkg::REG_ADDR_WIDTH-1:0]  rs_addr;
	logic [cpu_pkg::REG_ADDR_WIDTH-1:0]  rt_addr;
	logic [cpu_pkg::REG_WIDTH-1:0]       rs_value;
	logic [cpu_pkg::REG_WIDTH-1:0]       rt_value;
	logic                                wr_en;
	logic [cpu_pkg::REG_ADDR_WIDTH-1:0]  wr_addr;
	logic [cpu_pkg::REG_WIDTH-1:0]       wr_value;
	logic [cpu_pkg::REG_DEBUG_WIDTH-1:0] reg_debug_out;

	// Debug views
	logic [cpu_pkg::REG_WIDTH-1:0] exe_pc;
	logic [cpu_pkg::REG_WIDTH-1:0] exe_inst;
	logic [cpu_pkg::REG_WIDTH-1:0] alu_op1;
	logic [cpu_pkg::REG_WIDTH-1:0] alu_op2;
	logic [cpu_pkg::REG_WIDTH-1:0] alu_res;
	logic                          alu_flag;
	logic                          decoder_error;
	logic [cpu_pkg::REG_WIDTH-1:0] retired_cnt;

	inst_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_inst_queue (
		.clk        (clk),
		.rst        (rst),
		.inst_valid (inst_valid),
		.inst_data  (inst_data),
		.inst_ready (inst_ready),
		.q_pop      (q_pop),
		.q_valid    (q_valid),
		.q_head     (q_head),
		.qfront     (qfront),
		.qtail      (qtail)
	);

	reg_file u_reg_file (
		.clk           (clk),
		.rst           (rst),
		.rs_addr       (rs_addr),
		.rt_addr       (rt_addr),
		.rs_value      (rs_value),
		.rt_value      (rt_value),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_value      (wr_value),
		.reg_debug_out (reg_debug_out)
	);

	exe_stage u_exe_stage (
		.clk           (clk),
		.rst           (rst),
		.hold          (hold),
		.q_valid       (q_valid),
		.q_head        (q_head),
		.q_pop         (q_pop),
		.rs_addr       (rs_addr),
		.rt_addr       (rt_addr),
		.rs_value      (rs_value),
		.rt_value      (rt_value),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_value      (wr_value),
		.retire_valid  (retire_valid),
		.retire_write  (retire_write),
		.retire_addr   (retire_addr),
		.retire_value  (retire_value),
		.retire_error  (retire_error),
		.exe_pc        (exe_pc),
		.exe_inst      (exe_inst),
		.alu_op1       (alu_op1),
		.alu_op2       (alu_op2),
		.alu_res       (alu_res),
		.alu_flag      (alu_flag),
		.decoder_error (decoder_error),
		.retired_cnt   (retired_cnt)
	);

	led_ctrl #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_led_ctrl (
		.clk           (clk),
		.rst           (rst),
		.sw            (sw),
		.led_data      (led_data),
		.hold          (hold),
		.inst_ready    (inst_ready),
		.q_valid       (q_valid),
		.decoder_error (decoder_error),
		.alu_flag      (alu_flag),
		.exe_pc        (exe_pc),
		.exe_inst      (exe_inst),
		.alu_op1       (alu_op1),
		.alu_op2       (alu_op2),
		.alu_res       (alu_res),
		.retired_cnt   (retired_cnt),
		.reg_debug_out (reg_debug_out),
		.qfront        (qfront),
		.qtail         (qtail),
		.q_head        (q_head)
	);

endmodule

// ==== test/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb;

	localparam int QUEUE_DEPTH = 4;
	localparam int NUM_RANDOM  = 300;
	localparam int TOTAL_INSTS = NUM_RANDOM + QUEUE_DEPTH + 1;
	localparam int CYCLE_LIMIT = 20 * TOTAL_INSTS + 2000;

	logic        clk;
	logic        rst;
	logic        inst_valid;
	logic [15:0] inst_data;
	logic        inst_ready;
	logic        hold;
	logic [15:0] sw;
	logic [15:0] led_data;
	logic        retire_valid;
	logic        retire_write;
	logic [3:0]  retire_addr;
	logic [15:0] retire_value;
	logic        retire_error;

	cpu_core #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) DUT (
		.clk          (clk),
		.rst          (rst),
		.inst_valid   (inst_valid),
		.inst_data    (inst_data),
		.inst_ready   (inst_ready),
		.hold         (hold),
		.sw           (sw),
		.led_data     (led_data),
		.retire_valid (retire_valid),
		.retire_write (retire_write),
		.retire_addr  (retire_addr),
		.retire_value (retire_value),
		.retire_error (retire_error)
	);

	// Values applied at the next falling edge
	logic        drv_valid;
	logic [15:0] drv_data;
	logic        drv_hold;
	logic [15:0] drv_sw;
	logic        last_accepted;

	// Architectural model
	logic [15:0] model_regs [16];
	logic [15:0] model_q [$];
	int          seq_num;
	int          wr_cnt;
	int          rd_cnt;
	logic [15:0] last_inst;
	logic [15:0] last_op1;
	logic [15:0] last_op2;
	logic [15:0] last_res;
	logic [15:0] last_pc;
	logic        last_err;

	int    errors;
	int    test_err_start;
	int    tests_passed;
	int    tests_failed;
	int    cycle_count;
	string cur_test;

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////
	task automatic check_word(input string what, input logic [cpu_pkg::REG_WIDTH-1:0] exp,
			input logic [cpu_pkg::REG_WIDTH-1:0] act);
		if (act !== exp) begin
			$display("ERROR %s/%s: expected %h, actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_addr(input string what, input logic [cpu_pkg::REG_ADDR_WIDTH-1:0] exp,
			input logic [cpu_pkg::REG_ADDR_WIDTH-1:0] act);
		if (act !== exp) begin
			$display("ERROR %s/%s: expected %h, actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %s/%s: expected %b, actual %b", cur_test, what, exp, act);
			errors++;
		end
	endtask

	// Executes one instruction on the model registers
	function automatic void model_exec(input logic [15:0] word, output logic exp_write,
			output logic [3:0] exp_addr, output logic [15:0] exp_value, output logic exp_error);
		logic [3:0]  op;
		logic [7:0]  imm;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] r;
		op        = word[15:12];
		imm       = word[7:0];
		a         = model_regs[word[7:4]];
		b         = model_regs[word[3:0]];
		r         = '0;
		exp_error = 1'b0;
		case (op)
			cpu_pkg::OP_NOP: r = '0;
			cpu_pkg::OP_ADD: r = a + b;
			cpu_pkg::OP_SUB: r = a - b;
			cpu_pkg::OP_AND: r = a & b;
			cpu_pkg::OP_OR:  r = a | b;
			cpu_pkg::OP_XOR: r = a ^ b;
			cpu_pkg::OP_SLL: r = a << b[3:0];
			cpu_pkg::OP_LI: begin
				b = {8'h00, imm};
				r = b;
			end
			cpu_pkg::OP_ADDI: begin
				a = model_regs[word[11:8]];
				b = {{8{imm[7]}}, imm};
				r = a + b;
			end
			default: exp_error = 1'b1;
		endcase
		exp_write = (op != cpu_pkg::OP_NOP) && !exp_error;
		exp_addr  = word[11:8];
		exp_value = r;
		if (exp_write) begin
			model_regs[word[11:8]] = r;
		end
		last_pc   = 16'(seq_num);
		last_inst = word;
		last_op1  = a;
		last_op2  = b;
		last_res  = r;
		last_err  = exp_error;
		seq_num++;
	endfunction

	task automatic check_retire();
		logic [15:0] word;
		logic        ew;
		logic [3:0]  ea;
		logic [15:0] ev;
		logic        ee;
		if (retire_valid) begin
			if (model_q.size() == 0) begin
				$display("Retire seen with no instruction outstanding in %s", cur_test);
				errors++;
			end else begin
				word = model_q.pop_front();
				rd_cnt++;
				model_exec(word, ew, ea, ev, ee);
				check_bit("retire_write", ew, retire_write);
				check_addr("retire_addr", ea, retire_addr);
				check_word("retire_value", ev, retire_value);
				check_bit("retire_error", ee, retire_error);
			end
		end
	endtask

	// Retire check at the falling edge before the next inputs go out
	task automatic tick();
		@(negedge clk);
		check_retire();
		inst_valid    = drv_valid;
		inst_data     = drv_data;
		hold          = drv_hold;
		sw            = drv_sw;
		last_accepted = drv_valid && inst_ready;
		if (last_accepted) begin
			model_q.push_back(drv_data);
			wr_cnt++;
		end
	endtask

	task automatic read_view(input logic [7:0] code, output logic [15:0] val);
		drv_sw = {code, 8'($urandom)};
		tick();
		#20;
		val = led_data;
	endtask

	task automatic drain();
		while (model_q.size() != 0) begin
			tick();
		end
	endtask

	task automatic start_test(input string name);
		cur_test       = name;
		test_err_start = errors;
	endtask

	task automatic finish_test();
		if (errors == test_err_start) begin
			tests_passed++;
			$display("PASS %s", cur_test);
		end else begin
			tests_failed++;
			$display("FAIL %s (%0d errors)", cur_test, errors - test_err_start);
		end
	endtask

	function automatic bit is_mapped(input logic [7:0] code);
		return code inside {cpu_pkg::LED_STATUS, cpu_pkg::LED_ADDRS, cpu_pkg::LED_EXE_PC,
			cpu_pkg::LED_EXE_INST, cpu_pkg::LED_ALU_OP1, cpu_pkg::LED_ALU_OP2,
			cpu_pkg::LED_ALU_RES, cpu_pkg::LED_RETIRED, cpu_pkg::LED_QPTR,
			cpu_pkg::LED_QHEAD} || (code[7:4] == cpu_pkg::LED_REG_BASE[7:4]);
	endfunction

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		logic [15:0] val;
		logic [7:0]  code;
		int          sent;
		void'($urandom(32'h13aa_9bf5));
		rst        = 1'b1;
		inst_valid = 1'b0;
		inst_data  = '0;
		hold       = 1'b0;
		sw         = '0;
		drv_valid  = 1'b0;
		drv_data   = '0;
		drv_hold   = 1'b0;
		drv_sw     = '0;
		for (int i = 0; i < 16; i++) begin
			model_regs[i] = '0;
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		start_test("reset_state");
		read_view(cpu_pkg::LED_STATUS, val);
		check_word("status", 16'h2000, val);
		for (int i = 0; i < 16; i++) begin
			read_view(8'h3F - 8'(i), val);
			check_word($sformatf("reg%0d", i), 16'h0000, val);
		end
		read_view(cpu_pkg::LED_QPTR, val);
		check_word("qptr", 16'h0000, val);
		repeat (10) begin
			tick();
			check_bit("idle retire_valid", 1'b0, retire_valid);
		end
		finish_test();

		start_test("random_retire");
		sent = 0;
		while (sent < NUM_RANDOM) begin
			if (!drv_valid && ($urandom % 4 != 0)) begin
				drv_valid = 1'b1;
				drv_data  = 16'($urandom);
			end
			tick();
			if (last_accepted) begin
				sent++;
				drv_valid = 1'b0;
			end
		end
		drain();
		finish_test();

		start_test("register_dump");
		for (int i = 0; i < 16; i++) begin
			read_view(cpu_pkg::LED_REG_BASE + 8'(15 - i), val);
			check_word($sformatf("reg%0d", i), model_regs[i], val);
		end
		finish_test();

		start_test("hold_fill");
		drv_hold = 1'b1;
		for (int k = 0; k < QUEUE_DEPTH; k++) begin
			drv_valid = 1'b1;
			drv_data  = 16'($urandom);
			tick();
			check_bit($sformatf("accept%0d", k), 1'b1, last_accepted);
		end
		// One more held at the input while the queue is full
		drv_data = 16'($urandom);
		repeat (3) begin
			tick();
			check_bit("full accept", 1'b0, last_accepted);
			check_bit("full inst_ready", 1'b0, inst_ready);
			check_bit("hold retire_valid", 1'b0, retire_valid);
		end
		read_view(cpu_pkg::LED_QPTR, val);
		check_word("qptr", {8'(rd_cnt % QUEUE_DEPTH), 8'(wr_cnt % QUEUE_DEPTH)}, val);
		read_view(cpu_pkg::LED_QHEAD, val);
		check_word("qhead", model_q[0], val);
		drv_hold = 1'b0;
		do begin
			tick();
		end while (!last_accepted);
		drv_valid = 1'b0;
		drain();
		finish_test();

		start_test("debug_views");
		repeat (2) tick();
		read_view(cpu_pkg::LED_EXE_PC, val);
		check_word("exe_pc", last_pc, val);
		read_view(cpu_pkg::LED_EXE_INST, val);
		check_word("exe_inst", last_inst, val);
		read_view(cpu_pkg::LED_ALU_OP1, val);
		check_word("alu_op1", last_op1, val);
		read_view(cpu_pkg::LED_ALU_OP2, val);
		check_word("alu_op2", last_op2, val);
		read_view(cpu_pkg::LED_ALU_RES, val);
		check_word("alu_res", last_res, val);
		read_view(cpu_pkg::LED_ADDRS, val);
		check_word("addrs", {last_inst[11:0], 4'h0}, val);
		read_view(cpu_pkg::LED_RETIRED, val);
		check_word("retired", 16'(seq_num), val);
		// Idle and ready, flags of the last instruction
		read_view(cpu_pkg::LED_STATUS, val);
		check_word("status", {2'b00, 1'b1, 3'b000, last_err, 1'b0,
			(last_res == 16'h0000), 7'h00}, val);
		repeat (20) begin
			do begin
				code = 8'($urandom);
			end while (is_mapped(code));
			read_view(code, val);
			check_word($sformatf("unmapped %h", code), drv_sw, val);
		end
		finish_test();

		$display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== cpu_core.f ====
rtl/cpu_pkg.sv
rtl/inst_queue.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/exe_stage.sv
rtl/led_ctrl.sv
rtl/cpu_core.sv
test/cpu_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module cpu_core_tb \
	-f cpu_core.f --Mdir obj_dir -o cpu_core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

./obj_dir/cpu_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" sim.log; then
	echo "Simulation reported failures, see sim.log"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
